// File: bundle_pack.sv
`default_nettype none

module bundle_pack import decode_pkg::*; #(
  parameter int SUPER_SCALAR_WIDTH = 2,
  parameter int QUEUE_WIDTH = 4
) (
  input  wire logic [SUPER_SCALAR_WIDTH-1:0][INSN_W-1:0] fetched_ops,
  input  wire logic [PC_W-1:0]                           pc,
  output uop_t [QUEUE_WIDTH-1:0]                         lane_uops
);

  localparam int IDX_W = $clog2(QUEUE_WIDTH + 1);

  uop_t [SUPER_SCALAR_WIDTH-1:0][1:0]  slot_uops;
  logic [SUPER_SCALAR_WIDTH-1:0][1:0]  slot_count;
  logic [SUPER_SCALAR_WIDTH-1:0]       slot_stop;
  logic [IDX_W-1:0]                    idx;
  logic                                done;

  for (genvar i = 0; i < SUPER_SCALAR_WIDTH; i++) begin : g_slot
    decode_slot u_slot (
      .insn      (fetched_ops[i]),
      .slot_pc   (pc + PC_W'(4 * i)),
      .uops      (slot_uops[i]),
      .uop_count (slot_count[i]),
      .stop      (slot_stop[i])
    );
  end

  // append in program order, stop at the first branch
  always_comb begin
    lane_uops = '0;  // all-zero lane is a nop
    idx       = '0;
    done      = 1'b0;
    for (int s = 0; s < SUPER_SCALAR_WIDTH; s++) begin
      if (!done) begin
        if (slot_stop[s]) begin
          done = 1'b1;
        end else begin
          if (slot_count[s] != 2'd0) begin
            lane_uops[idx] = slot_uops[s][0];
            idx = idx + 1'b1;
          end
          if (slot_count[s] == 2'd2) begin
            lane_uops[idx] = slot_uops[s][1];
            idx = idx + 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: decode_chk.sv
`default_nettype none

module decode_chk import decode_pkg::*; #(
  parameter int QUEUE_WIDTH = 4
) (
  input wire logic                   clk_in,
  input wire logic                   rst,
  input wire logic                   flush,
  input wire logic                   fetch_valid,
  input wire logic                   exe_ready,
  input wire logic                   decode_ready,
  input wire uop_t [QUEUE_WIDTH-1:0] lanes
);

  logic parked;  // a bundle waits in the skid buffer

  always_ff @(posedge clk_in) begin
    if (rst || flush)
      parked <= 1'b0;
    else if (exe_ready)
      parked <= 1'b0;
    else if (fetch_valid && decode_ready)
      parked <= 1'b1;
  end

  a_clear_ready: assert property (@(posedge clk_in) (rst || flush) |=> !decode_ready)
    else $error("decode_ready high in the cycle after rst or flush");

  // buffered and execute still stalled
  a_parked_ready: assert property (@(posedge clk_in)
    (!rst && !flush && !exe_ready && (parked || (fetch_valid && decode_ready)))
      |=> !decode_ready)
    else $error("decode_ready high while a bundle is buffered");

  a_lanes_hold: assert property (@(posedge clk_in)
    (!rst && !flush && !exe_ready) |=> $stable(lanes))
    else $error("lanes changed while exe_ready was low");

endmodule

bind decode_top decode_chk #(.QUEUE_WIDTH(QUEUE_WIDTH)) u_chk (
  .clk_in       (clk_in),
  .rst          (rst),
  .flush        (flush),
  .fetch_valid  (fetch_valid),
  .exe_ready    (exe_ready),
  .decode_ready (decode_ready),
  .lanes        (lanes)
);

`default_nettype wire

// File: decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int INSN_W = 32;
  localparam int PC_W = 64;

  // instruction classes kept by the decoder
  typedef enum logic [3:0] {
    CLS_ADD_I,
    CLS_SUB_I,
    CLS_ADDS_R,
    CLS_SUBS_R,   // also cmp
    CLS_ORR_R,
    CLS_EOR_R,
    CLS_ANDS_R,   // also tst
    CLS_MOVZ,
    CLS_MOVK,
    CLS_LDUR,
    CLS_STUR,
    CLS_B,
    CLS_NOP,
    CLS_UNKNOWN
  } insn_class_e;

  typedef enum logic [3:0] {
    UOP_NOP = 4'd0,  // empty lane, all-zero uop
    UOP_ADD,
    UOP_SUB,
    UOP_ORR,
    UOP_EOR,
    UOP_AND,
    UOP_MOVZ,
    UOP_MOVK,
    UOP_LOAD,
    UOP_STORE
  } uop_op_e;

  typedef struct packed {
    logic [4:0] gpr;
    logic       is_sp;
  } reg_ref_t;

  typedef struct packed {
    uop_op_e         uopcode;
    reg_ref_t        dst;
    reg_ref_t        src1;
    reg_ref_t        src2;
    logic [20:0]     imm;
    logic [1:0]      hw;         // movz/movk shift, in units of 16 bits
    logic            valb_sel;   // 1 = second operand from src2
    logic            mem_read;
    logic            mem_write;
    logic            w_enable;
    logic            tx_begin;   // first uop of an instruction
    logic            tx_end;     // last uop of an instruction
    logic [PC_W-1:0] pc;
  } uop_t;

endpackage

`default_nettype wire

// File: decode_skid.sv
`default_nettype none

module decode_skid import decode_pkg::*; #(
  parameter int QUEUE_WIDTH = 4
) (
  input  wire logic              clk_in,
  input  wire logic              rst,
  input  wire logic              flush,
  input  wire logic              fetch_valid,
  input  wire logic              exe_ready,
  input  wire uop_t [QUEUE_WIDTH-1:0] next_lanes,
  output logic                   decode_ready,
  output uop_t [QUEUE_WIDTH-1:0] lanes
);

  uop_t [QUEUE_WIDTH-1:0] buf_lanes;  // one parked bundle
  logic                   buf_full;
  logic                   buf_full_next;
  logic                   accept;

  assign accept = fetch_valid && decode_ready;

  // buffer drains whenever execute takes lanes
  assign buf_full_next = exe_ready ? 1'b0 : (buf_full || accept);

  always_ff @(posedge clk_in) begin
    if (rst || flush) begin
      lanes        <= '0;
      buf_full     <= 1'b0;
      decode_ready <= 1'b0;  // low for one cycle after clear
    end else begin
      if (exe_ready) begin
        if (buf_full)
          lanes <= buf_lanes;
        else if (accept)
          lanes <= next_lanes;
        else
          lanes <= '0;
      end
      buf_full     <= buf_full_next;
      decode_ready <= !buf_full_next;
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept && !exe_ready)
      buf_lanes <= next_lanes;  // stalled, park it
  end

endmodule

`default_nettype wire

// File: decode_slot.sv
`default_nettype none

module decode_slot import decode_pkg::*; (
  input  wire logic [INSN_W-1:0] insn,
  input  wire logic [PC_W-1:0]   slot_pc,
  output uop_t [1:0]             uops,
  output logic [1:0]             uop_count,
  output logic                   stop
);

  insn_class_e cls;
  logic [4:0]  rd;
  logic [4:0]  rn;
  logic [4:0]  rm;
  logic [8:0]  imm9;
  uop_t        alu;
  uop_t        mem;

  assign rd   = insn[4:0];
  assign rn   = insn[9:5];
  assign rm   = insn[20:16];
  assign imm9 = insn[20:12];

  // 64-bit A64 forms only
  function automatic insn_class_e classify(input logic [INSN_W-1:0] op);
    insn_class_e c;
    c = CLS_UNKNOWN;
    if (op == 32'hd503201f) c = CLS_NOP;
    else if (op[31:26] == 6'b000101) c = CLS_B;
    else if (op[31:22] == 10'b1001000100) c = CLS_ADD_I;
    else if (op[31:22] == 10'b1101000100) c = CLS_SUB_I;
    else if (op[31:21] == 11'b10101011000) c = CLS_ADDS_R;
    else if (op[31:21] == 11'b11101011000) c = CLS_SUBS_R;
    else if (op[31:21] == 11'b10101010000) c = CLS_ORR_R;
    else if (op[31:21] == 11'b11001010000) c = CLS_EOR_R;
    else if (op[31:21] == 11'b11101010000) c = CLS_ANDS_R;
    else if (op[31:23] == 9'b110100101) c = CLS_MOVZ;
    else if (op[31:23] == 9'b111100101) c = CLS_MOVK;
    else if (op[31:21] == 11'b11111000010 && op[11:10] == 2'b00) c = CLS_LDUR;
    else if (op[31:21] == 11'b11111000000 && op[11:10] == 2'b00) c = CLS_STUR;
    return c;
  endfunction

  always_comb begin
    cls       = classify(insn);
    uops      = '0;
    uop_count = 2'd0;
    stop      = 1'b0;

    // common shape of alu and move uops
    alu          = '0;
    alu.dst.gpr  = rd;
    alu.w_enable = 1'b1;
    alu.tx_begin = 1'b1;
    alu.tx_end   = 1'b1;
    alu.pc       = slot_pc;

    // memory access, rt rides in dst
    mem           = '0;
    mem.uopcode   = (cls == CLS_LDUR) ? UOP_LOAD : UOP_STORE;
    mem.dst.gpr   = rd;
    mem.mem_read  = (cls == CLS_LDUR);
    mem.mem_write = (cls == CLS_STUR);
    mem.w_enable  = (cls == CLS_LDUR);
    mem.tx_end    = 1'b1;
    mem.pc        = slot_pc;

    case (cls)
      CLS_ADD_I, CLS_SUB_I: begin
        uops[0]            = alu;
        uops[0].uopcode    = (cls == CLS_ADD_I) ? UOP_ADD : UOP_SUB;
        uops[0].dst.is_sp  = (&rd) & (&rn);
        uops[0].src1       = '{gpr: rn, is_sp: &rn};
        uops[0].imm        = 21'(insn[21:10]);
        uop_count          = 2'd1;
      end
      CLS_ADDS_R, CLS_SUBS_R, CLS_ORR_R, CLS_EOR_R, CLS_ANDS_R: begin
        uops[0]          = alu;
        uops[0].src1.gpr = rn;
        uops[0].src2.gpr = rm;
        uops[0].valb_sel = 1'b1;
        case (cls)
          CLS_ADDS_R: uops[0].uopcode = UOP_ADD;
          CLS_SUBS_R: uops[0].uopcode = UOP_SUB;
          CLS_ORR_R:  uops[0].uopcode = UOP_ORR;
          CLS_EOR_R:  uops[0].uopcode = UOP_EOR;
          default:    uops[0].uopcode = UOP_AND;
        endcase
        uop_count = 2'd1;
      end
      CLS_MOVZ, CLS_MOVK: begin
        uops[0]         = alu;
        uops[0].uopcode = (cls == CLS_MOVZ) ? UOP_MOVZ : UOP_MOVK;
        uops[0].imm     = 21'(insn[20:5]);
        uops[0].hw      = insn[22:21];
        uop_count       = 2'd1;
      end
      CLS_LDUR, CLS_STUR: begin
        if (imm9 != 9'd0) begin
          // rd <- rn + imm9, then access through rd
          uops[0]         = alu;
          uops[0].uopcode = UOP_ADD;
          uops[0].src1    = '{gpr: rn, is_sp: &rn};
          uops[0].imm     = 21'(imm9);
          uops[0].tx_end  = 1'b0;
          uops[1]          = mem;
          uops[1].src1.gpr = rd;
          uop_count        = 2'd2;
        end else begin
          uops[0]          = mem;
          uops[0].src1     = '{gpr: rn, is_sp: &rn};
          uops[0].tx_begin = 1'b1;
          uop_count        = 2'd1;
        end
      end
      CLS_B: stop = 1'b1;  // rest of the bundle is dead
      default: ;           // nop and unknown make nothing
    endcase
  end

endmodule

`default_nettype wire

// File: decode_tb.sv
`default_nettype none

module decode_tb import decode_pkg::*; ();

  localparam int SSW = 2;
  localparam int QW = 2 * SSW;

  typedef uop_t [QW-1:0] lanes_t;
  typedef struct packed {
    insn_class_e cls;
    logic [4:0]  rd;
    logic [4:0]  rn;
    logic [4:0]  rm;
    logic [15:0] imm;  // imm12, imm16 or imm9 from the low bits
    logic [1:0]  hw;
  } slot_t;
  typedef slot_t [SSW-1:0] bundle_t;

  logic                       clk_in;
  logic                       rst;
  logic                       flush;
  logic                       fetch_valid;
  logic                       exe_ready;
  logic [SSW-1:0][INSN_W-1:0] fetched_ops;
  logic [PC_W-1:0]            pc;
  logic                       decode_ready;
  lanes_t                     lanes;

  logic [15:0] lfsr = 16'd85;
  lanes_t      exp_q[$];  // accepted bundles not yet seen on lanes
  lanes_t      shown;     // what the model puts on lanes now
  int          checks;
  int          errors;
  int          mark;
  bundle_t     b;

  decode_top #(.SUPER_SCALAR_WIDTH(SSW)) uut (
    .clk_in(clk_in), .rst(rst), .flush(flush), .fetched_ops(fetched_ops), .pc(pc),
    .fetch_valid(fetch_valid), .exe_ready(exe_ready), .decode_ready(decode_ready),
    .lanes(lanes)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] encode(input slot_t s);
    case (s.cls)
      CLS_ADD_I:  return {10'b1001000100, s.imm[11:0], s.rn, s.rd};
      CLS_SUB_I:  return {10'b1101000100, s.imm[11:0], s.rn, s.rd};
      CLS_ADDS_R: return {11'b10101011000, s.rm, 6'd0, s.rn, s.rd};
      CLS_SUBS_R: return {11'b11101011000, s.rm, 6'd0, s.rn, s.rd};
      CLS_ORR_R:  return {11'b10101010000, s.rm, 6'd0, s.rn, s.rd};
      CLS_EOR_R:  return {11'b11001010000, s.rm, 6'd0, s.rn, s.rd};
      CLS_ANDS_R: return {11'b11101010000, s.rm, 6'd0, s.rn, s.rd};
      CLS_MOVZ:   return {9'b110100101, s.hw, s.imm, s.rd};
      CLS_MOVK:   return {9'b111100101, s.hw, s.imm, s.rd};
      CLS_LDUR:   return {11'b11111000010, s.imm[8:0], 2'b00, s.rn, s.rd};
      CLS_STUR:   return {11'b11111000000, s.imm[8:0], 2'b00, s.rn, s.rd};
      CLS_B:      return {6'b000101, 10'd0, s.imm};
      CLS_NOP:    return 32'hd503201f;
      default:    return 32'h0000_0000;  // udf
    endcase
  endfunction

  function automatic void make_uops(input slot_t s, input logic [PC_W-1:0] spc,
                                    output uop_t u0, output uop_t u1, output int cnt);
    uop_t mem;
    u0 = '0;
    u0.dst.gpr = s.rd;
    u0.w_enable = 1'b1;
    u0.tx_begin = 1'b1;
    u0.tx_end = 1'b1;
    u0.pc = spc;
    u1 = '0;
    mem = '0;
    mem.uopcode = (s.cls == CLS_LDUR) ? UOP_LOAD : UOP_STORE;
    mem.dst.gpr = s.rd;  // rt travels in dst
    mem.mem_read = (s.cls == CLS_LDUR);
    mem.w_enable = (s.cls == CLS_LDUR);
    mem.mem_write = (s.cls == CLS_STUR);
    mem.tx_end = 1'b1;
    mem.pc = spc;
    cnt = 1;
    case (s.cls)
      CLS_ADD_I, CLS_SUB_I: begin
        u0.uopcode = (s.cls == CLS_ADD_I) ? UOP_ADD : UOP_SUB;
        u0.src1 = '{gpr: s.rn, is_sp: s.rn == 5'd31};
        u0.dst.is_sp = (s.rd == 5'd31) && (s.rn == 5'd31);
        u0.imm = 21'(s.imm[11:0]);
      end
      CLS_ADDS_R, CLS_SUBS_R, CLS_ORR_R, CLS_EOR_R, CLS_ANDS_R: begin
        u0.uopcode = (s.cls == CLS_ADDS_R) ? UOP_ADD : (s.cls == CLS_SUBS_R) ? UOP_SUB :
                     (s.cls == CLS_ORR_R) ? UOP_ORR : (s.cls == CLS_EOR_R) ? UOP_EOR : UOP_AND;
        u0.src1.gpr = s.rn;
        u0.src2.gpr = s.rm;
        u0.valb_sel = 1'b1;
      end
      CLS_MOVZ, CLS_MOVK: begin
        u0.uopcode = (s.cls == CLS_MOVZ) ? UOP_MOVZ : UOP_MOVK;
        u0.imm = 21'(s.imm);
        u0.hw = s.hw;
      end
      CLS_LDUR, CLS_STUR: begin
        if (s.imm[8:0] != 9'd0) begin
          u0.uopcode = UOP_ADD;  // address add then the access through rd
          u0.src1 = '{gpr: s.rn, is_sp: s.rn == 5'd31};
          u0.imm = 21'(s.imm[8:0]);
          u0.tx_end = 1'b0;
          u1 = mem;
          u1.src1.gpr = s.rd;
          cnt = 2;
        end else begin
          u0 = mem;
          u0.src1 = '{gpr: s.rn, is_sp: s.rn == 5'd31};
          u0.tx_begin = 1'b1;
        end
      end
      default: cnt = 0;
    endcase
  endfunction

  function automatic lanes_t expect_bundle(input bundle_t bb, input logic [PC_W-1:0] base);
    lanes_t l;
    uop_t   u0;
    uop_t   u1;
    int     cnt;
    int     n;
    logic   stopped;
    l = '0;
    n = 0;
    stopped = 1'b0;
    for (int i = 0; i < SSW; i++) begin
      if (bb[i].cls == CLS_B) stopped = 1'b1;  // later slots are dead
      if (!stopped) begin
        make_uops(bb[i], base + 64'(4 * i), u0, u1, cnt);
        if (cnt > 0) l[n] = u0;
        if (cnt > 1) l[n + 1] = u1;
        n = n + cnt;
      end
    end
    return l;
  endfunction

  function automatic slot_t rand_slot(input int kind);
    slot_t s;
    s.rd = 5'(rand_bits(5));
    s.rn = 5'(rand_bits(5));
    s.rm = 5'(rand_bits(5));
    s.imm = 16'(rand_bits(16));
    s.hw = 2'(rand_bits(2));
    if (kind == 0)
      s.cls = insn_class_e'(4'(rand_bits(4) % 9));  // alu and move classes
    else
      s.cls = (rand_bits(1) != 0) ? CLS_LDUR : CLS_STUR;
    return s;
  endfunction

  task automatic check_lanes(input lanes_t exp);
    for (int l = 0; l < QW; l++) begin
      checks++;
      assert (lanes[l] == exp[l]) else begin
        $display("FAILED lanes[%0d] expected %h got %h", l, exp[l], lanes[l]);
        errors++;
      end
    end
  endtask

  task automatic check_ready(input logic want);
    checks++;
    assert (decode_ready == want) else begin
      $display("FAILED decode_ready expected %h got %h", want, decode_ready);
      errors++;
    end
  endtask

  // one clock from falling edge to falling edge
  task automatic step(input bundle_t bb, input logic [PC_W-1:0] base, input logic valid,
                      input logic ex, input logic fl, output logic accepted);
    lanes_t exp;
    for (int i = 0; i < SSW; i++)
      fetched_ops[i] = encode(bb[i]);
    pc = base;
    fetch_valid = valid;
    exe_ready = ex;
    flush = fl;
    accepted = valid && decode_ready && !fl;
    if (fl)
      exp_q.delete();
    else if (accepted)
      exp_q.push_back(expect_bundle(bb, base));
    @(negedge clk_in);
    if (fl)
      exp = '0;
    else if (!ex)
      exp = shown;
    else if (exp_q.size() > 0)
      exp = exp_q.pop_front();
    else
      exp = '0;
    check_lanes(exp);
    shown = exp;
    if (accepted && !ex) check_ready(1'b0);  // parked in the skid buffer
  endtask

  // mode 0 ready, 1 random stalls, 2 stalled
  task automatic send(input bundle_t bb, input int mode);
    logic [PC_W-1:0] base;
    logic            ex;
    logic            acc;
    int              tries;
    base = 64'h0000_4000_0000_0000 | (64'(rand_bits(28)) << 2);
    acc = 1'b0;
    tries = 0;
    while (!acc && tries < 40) begin
      ex = (mode == 0) || (mode == 1 && rand_bits(2) != 0);
      step(bb, base, 1'b1, ex, 1'b0, acc);
      tries++;
    end
    if (!acc) begin
      $display("timed out waiting for decode_ready to take a bundle");
      errors++;
    end
  endtask

  task automatic drain();
    logic acc;
    int   tries;
    tries = 0;
    while ((exp_q.size() > 0 || !decode_ready) && tries < 20) begin
      step('0, '0, 1'b0, 1'b1, 1'b0, acc);
      tries++;
    end
    if (exp_q.size() > 0 || !decode_ready) begin
      $display("timed out draining the skid buffer");
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done with %0d errors", name, errors - mark);
    mark = errors;
  endtask

  initial begin
    logic acc;
    rst = 1'b1;
    flush = 1'b0;
    fetch_valid = 1'b0;
    exe_ready = 1'b1;
    fetched_ops = '0;
    pc = '0;
    shown = '0;
    checks = 0;
    errors = 0;
    mark = 0;
    repeat (16) @(negedge clk_in);
    check_ready(1'b0);
    check_lanes('0);
    rst = 1'b0;
    step('0, '0, 1'b0, 1'b1, 1'b0, acc);
    check_ready(1'b1);
    finish_test("reset");

    repeat (20) begin
      for (int i = 0; i < SSW; i++) b[i] = rand_slot(0);
      send(b, 0);
    end
    drain();
    finish_test("alu_move");

    b[0] = rand_slot(1);
    b[1] = rand_slot(1);
    b[0].cls = CLS_LDUR;
    b[1].cls = CLS_STUR;
    b[0].imm[0] = 1'b1;
    b[1].imm[0] = 1'b1;
    send(b, 0);  // both split so all four lanes fill
    b[0].imm[8:0] = 9'd0;
    send(b, 0);
    b[0].imm[0] = 1'b1;
    b[1].imm[8:0] = 9'd0;
    send(b, 0);
    repeat (10) begin
      for (int i = 0; i < SSW; i++) b[i] = rand_slot(1);
      send(b, 0);
    end
    drain();
    finish_test("memory");

    b[0] = rand_slot(0);
    b[1] = rand_slot(1);
    b[0].cls = CLS_B;
    send(b, 0);
    b[0] = rand_slot(0);
    b[1].cls = CLS_B;
    send(b, 0);
    b[0].cls = CLS_NOP;
    b[1] = rand_slot(1);
    send(b, 0);
    b[0].cls = CLS_UNKNOWN;
    b[1] = rand_slot(0);
    send(b, 0);
    drain();
    finish_test("branch_nop");

    repeat (40) begin
      for (int i = 0; i < SSW; i++) b[i] = rand_slot(int'(rand_bits(1)));
      send(b, 1);
    end
    drain();
    finish_test("stall");

    for (int i = 0; i < SSW; i++) b[i] = rand_slot(0);
    send(b, 2);
    step('0, '0, 1'b0, 1'b0, 1'b1, acc);  // flush drops the parked bundle
    step('0, '0, 1'b0, 1'b1, 1'b0, acc);
    for (int i = 0; i < SSW; i++) b[i] = rand_slot(1);
    send(b, 0);
    drain();
    finish_test("flush");

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: decode_top.sv
`default_nettype none

module decode_top import decode_pkg::*; #(
  parameter int SUPER_SCALAR_WIDTH = 2,
  parameter int QUEUE_WIDTH = 2 * SUPER_SCALAR_WIDTH  // room for a bundle of split accesses
) (
  input  wire logic                                      clk_in,
  input  wire logic                                      rst,
  input  wire logic                                      flush,
  input  wire logic [SUPER_SCALAR_WIDTH-1:0][INSN_W-1:0] fetched_ops,
  input  wire logic [PC_W-1:0]                           pc,
  input  wire logic                                      fetch_valid,
  input  wire logic                                      exe_ready,
  output logic                                           decode_ready,
  output uop_t [QUEUE_WIDTH-1:0]                         lanes
);

  uop_t [QUEUE_WIDTH-1:0] next_lanes;

  bundle_pack #(
    .SUPER_SCALAR_WIDTH (SUPER_SCALAR_WIDTH),
    .QUEUE_WIDTH        (QUEUE_WIDTH)
  ) u_pack (
    .fetched_ops (fetched_ops),
    .pc          (pc),
    .lane_uops   (next_lanes)
  );

  decode_skid #(
    .QUEUE_WIDTH (QUEUE_WIDTH)
  ) u_skid (
    .clk_in       (clk_in),
    .rst          (rst),
    .flush        (flush),
    .fetch_valid  (fetch_valid),
    .exe_ready    (exe_ready),
    .next_lanes   (next_lanes),
    .decode_ready (decode_ready),
    .lanes        (lanes)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module decode_tb -f verilog.f
./obj_dir/Vdecode_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "sim failed" sim.log; then
  exit 1
fi

// File: verilog.f
decode_pkg.sv
decode_slot.sv
bundle_pack.sv
decode_skid.sv
decode_top.sv
decode_chk.sv
decode_tb.sv
